/* cpu900_decode.f */
hdl/cpu900_isa_pkg.sv
hdl/cpu900_ctrl_pkg.sv
hdl/op_field_decode.sv
hdl/phase_sequencer.sv
hdl/alu_issue_regs.sv
hdl/cpu900_decode.sv
verif/cpu900_decode_tb.sv

/* hdl/alu_issue_regs.sv */
// ----------------------------------------
// Registered ALU and register-file
// controls with immediate assembly
// ----------------------------------------
`timescale 1ns/1ps

module alu_issue_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    input  cpu900_isa_pkg::op_word_t   op,
    input  logic                       issue,
    input  cpu900_isa_pkg::alu_op_t    cmd_alu_op,
    input  cpu900_isa_pkg::reg_code_t  cmd_dst,
    input  cpu900_isa_pkg::reg_code_t  cmd_src,
    input  cpu900_ctrl_pkg::we_mask_t  cmd_we,
    input  logic                       cmd_flag_we,
    input  logic                       cmd_smux,
    input  logic                       cmd_inc_rfp,
    input  logic                       cmd_dec_rfp,
    input  cpu900_ctrl_pkg::imm_load_t cmd_imm,
    input  logic                       cmd_fill_wait,
    output cpu900_isa_pkg::alu_op_t    alu_op,
    output cpu900_isa_pkg::op_word_t   alu_imm,
    output logic                       alu_smux,
    output logic                       alu_wait,
    output cpu900_ctrl_pkg::we_mask_t  regs_we,
    output logic                       flag_we,
    output cpu900_isa_pkg::reg_code_t  regs_dst,
    output cpu900_isa_pkg::reg_code_t  regs_src,
    output logic                       inc_rfp,
    output logic                       dec_rfp
);
    import cpu900_isa_pkg::*;
    import cpu900_ctrl_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_op   <= ALU_NOP;
            alu_imm  <= '0;
            alu_smux <= 1'b0;
            alu_wait <= 1'b0;
            regs_we  <= '0;
            flag_we  <= 1'b0;
            regs_dst <= '0;
            regs_src <= '0;
            inc_rfp  <= 1'b0;
            dec_rfp  <= 1'b0;
        end else if (cen) begin
            // Pulses last a single cen cycle
            regs_we <= issue ? cmd_we : '0;
            flag_we <= issue && cmd_flag_we;
            inc_rfp <= issue && cmd_inc_rfp;
            dec_rfp <= issue && cmd_dec_rfp;
            if (issue) begin
                alu_op   <= cmd_alu_op;
                alu_smux <= cmd_smux;
                alu_wait <= cmd_fill_wait;  // High through FILL_IMM
                regs_dst <= cmd_dst;
                regs_src <= cmd_src;
                case (cmd_imm)
                    IMM_BYTE:   alu_imm <= {24'd0, op[15:8]};
                    IMM_SHORT3: alu_imm <= {29'd0, op[2:0]};
                    IMM_HI16:   alu_imm[31:8] <= {16'd0, op[7:0]};  // Low byte kept
                    IMM_HI24:   alu_imm[31:8] <= op[23:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hdl/cpu900_ctrl_pkg.sv */
// ----------------------------------------
// Controller types: phases, byte counts,
// write masks and command kinds
// ----------------------------------------
package cpu900_ctrl_pkg;

    typedef enum logic [1:0] {
        PH_FETCH,
        PH_EXEC,
        PH_FILL_IMM
    } phase_t;

    typedef logic [1:0] fetch_cnt_t;  // Bytes consumed in one decode cycle
    typedef logic [2:0] we_mask_t;    // Bit 0 byte, bit 1 word, bit 2 long

    typedef enum logic [2:0] {
        LEAD_NOP,
        LEAD_CCF,
        LEAD_INCF,
        LEAD_DECF,
        LEAD_LD_IMM,
        LEAD_REG_PREFIX,
        LEAD_UNKNOWN
    } lead_class_t;

    typedef enum logic [2:0] {
        EX_ARITH_RR,
        EX_LD_RR,
        EX_INC_DEC,
        EX_UNARY,
        EX_NONE
    } exec_kind_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_BYTE,
        IMM_SHORT3,
        IMM_HI16,
        IMM_HI24
    } imm_load_t;

    function automatic we_mask_t size_mask(cpu900_isa_pkg::size_t zz);
        case (zz)
            2'd0:    return 3'b001;
            2'd1:    return 3'b010;
            default: return 3'b100;
        endcase
    endfunction

endpackage

/* hdl/cpu900_decode.sv */
// ----------------------------------------
// Instruction decode controller top level
// ----------------------------------------
`timescale 1ns/1ps

module cpu900_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cen,
    input  cpu900_isa_pkg::op_word_t    op,
    input  logic                        op_ok,
    output cpu900_ctrl_pkg::fetch_cnt_t fetched,
    output cpu900_isa_pkg::alu_op_t     alu_op,
    output cpu900_isa_pkg::op_word_t    alu_imm,
    output logic                        alu_smux,
    output logic                        alu_wait,
    output logic                        flag_we,
    output logic                        inc_rfp,
    output logic                        dec_rfp,
    output cpu900_ctrl_pkg::we_mask_t   regs_we,
    output cpu900_isa_pkg::reg_code_t   regs_dst,
    output cpu900_isa_pkg::reg_code_t   regs_src
);
    import cpu900_isa_pkg::*;
    import cpu900_ctrl_pkg::*;

    lead_class_t lead_class;
    size_t       lead_zz;
    size_t       op_zz;
    reg_code_t   lead_reg;
    exec_kind_t  exec_kind;
    alu_op_t     exec_alu_op;
    reg_code_t   exec_reg;
    logic        exec_flags;
    logic        issue;
    alu_op_t     cmd_alu_op;
    reg_code_t   cmd_dst;
    reg_code_t   cmd_src;
    we_mask_t    cmd_we;
    logic        cmd_flag_we;
    logic        cmd_smux;
    logic        cmd_inc_rfp;
    logic        cmd_dec_rfp;
    imm_load_t   cmd_imm;
    logic        cmd_fill_wait;

    op_field_decode u_op_field_decode (
        .op          (op),
        .op_zz       (op_zz),
        .lead_class  (lead_class),
        .lead_zz     (lead_zz),
        .lead_reg    (lead_reg),
        .exec_kind   (exec_kind),
        .exec_alu_op (exec_alu_op),
        .exec_reg    (exec_reg),
        .exec_flags  (exec_flags)
    );

    phase_sequencer u_phase_sequencer (
        .clk           (clk),
        .rst           (rst),
        .cen           (cen),
        .op_ok         (op_ok),
        .lead_class    (lead_class),
        .lead_zz       (lead_zz),
        .lead_reg      (lead_reg),
        .exec_kind     (exec_kind),
        .exec_alu_op   (exec_alu_op),
        .exec_reg      (exec_reg),
        .exec_flags    (exec_flags),
        .fetched       (fetched),
        .op_zz         (op_zz),
        .issue         (issue),
        .cmd_alu_op    (cmd_alu_op),
        .cmd_dst       (cmd_dst),
        .cmd_src       (cmd_src),
        .cmd_we        (cmd_we),
        .cmd_flag_we   (cmd_flag_we),
        .cmd_smux      (cmd_smux),
        .cmd_inc_rfp   (cmd_inc_rfp),
        .cmd_dec_rfp   (cmd_dec_rfp),
        .cmd_imm       (cmd_imm),
        .cmd_fill_wait (cmd_fill_wait)
    );

    alu_issue_regs u_alu_issue_regs (
        .clk           (clk),
        .rst           (rst),
        .cen           (cen),
        .op            (op),
        .issue         (issue),
        .cmd_alu_op    (cmd_alu_op),
        .cmd_dst       (cmd_dst),
        .cmd_src       (cmd_src),
        .cmd_we        (cmd_we),
        .cmd_flag_we   (cmd_flag_we),
        .cmd_smux      (cmd_smux),
        .cmd_inc_rfp   (cmd_inc_rfp),
        .cmd_dec_rfp   (cmd_dec_rfp),
        .cmd_imm       (cmd_imm),
        .cmd_fill_wait (cmd_fill_wait),
        .alu_op        (alu_op),
        .alu_imm       (alu_imm),
        .alu_smux      (alu_smux),
        .alu_wait      (alu_wait),
        .regs_we       (regs_we),
        .flag_we       (flag_we),
        .regs_dst      (regs_dst),
        .regs_src      (regs_src),
        .inc_rfp       (inc_rfp),
        .dec_rfp       (dec_rfp)
    );

endmodule

/* hdl/cpu900_isa_pkg.sv */
// ----------------------------------------
// Instruction-set types: opcode window,
// operand sizes, register codes, ALU ops
// and the register field expansion
// ----------------------------------------
package cpu900_isa_pkg;

    typedef logic [31:0] op_word_t;    // Four bytes, op[7:0] is the next one
    typedef logic [1:0]  size_t;       // 0 byte, 1 word, 2 long
    typedef logic [2:0]  short_reg_t;  // Register field inside an opcode
    typedef logic [7:0]  reg_code_t;   // Full register file code

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_WORD = 2'd1;
    localparam size_t SIZE_LONG = 2'd2;

    typedef enum logic [5:0] {
        ALU_NOP  = 6'd0,
        ALU_MOVE = 6'd1,
        ALU_ADD  = 6'd2,
        ALU_ADC  = 6'd3,
        ALU_SUB  = 6'd4,
        ALU_AND  = 6'd5,
        ALU_XOR  = 6'd6,
        ALU_OR   = 6'd7,
        ALU_CP   = 6'd8,
        ALU_INC  = 6'd9,
        ALU_DEC  = 6'd10,
        ALU_NEG  = 6'd11,
        ALU_CPL  = 6'd12,
        ALU_CCF  = 6'd13
    } alu_op_t;

    // Byte registers pair up as E1/E0, E5/E4 and so on
    function automatic reg_code_t expand_reg(short_reg_t r, size_t zz);
        reg_code_t code;
        if (zz == SIZE_BYTE) begin
            code = 8'he0 + {4'd0, r[2:1], 2'd0} + {7'd0, ~r[0]};
        end else begin
            code = (r[2] ? 8'hf0 : 8'he0) + {4'd0, r[1:0], 2'd0};
        end
        return code;
    endfunction

endpackage

/* hdl/op_field_decode.sv */
// ----------------------------------------
// Opcode byte classifier: lead byte and
// second byte of a register prefix
// ----------------------------------------
`timescale 1ns/1ps

module op_field_decode (
    input  cpu900_isa_pkg::op_word_t     op,
    input  cpu900_isa_pkg::size_t        op_zz,
    output cpu900_ctrl_pkg::lead_class_t lead_class,
    output cpu900_isa_pkg::size_t        lead_zz,
    output cpu900_isa_pkg::reg_code_t    lead_reg,
    output cpu900_ctrl_pkg::exec_kind_t  exec_kind,
    output cpu900_isa_pkg::alu_op_t      exec_alu_op,
    output cpu900_isa_pkg::reg_code_t    exec_reg,
    output logic                         exec_flags
);
    import cpu900_isa_pkg::*;
    import cpu900_ctrl_pkg::*;

    logic [7:0] b;

    assign b = op[7:0];

    always_comb begin
        lead_class = LEAD_UNKNOWN;
        lead_zz    = SIZE_BYTE;
        casez (b)
            8'h00: lead_class = LEAD_NOP;
            8'h12: lead_class = LEAD_CCF;
            8'h0c: lead_class = LEAD_INCF;
            8'h0d: lead_class = LEAD_DECF;
            8'b0010_0???: lead_class = LEAD_LD_IMM;  // LD R,# byte
            8'b0011_0???: begin
                lead_class = LEAD_LD_IMM;
                lead_zz    = SIZE_WORD;
            end
            8'b0100_0???: begin
                lead_class = LEAD_LD_IMM;
                lead_zz    = SIZE_LONG;
            end
            8'b11??_1???: begin
                if (b[5:4] != 2'd3) begin   // zz of 3 is not a register size
                    lead_class = LEAD_REG_PREFIX;
                    lead_zz    = b[5:4];
                end
            end
            default: ;
        endcase
    end

    assign lead_reg = expand_reg(b[2:0], lead_zz);

    // Second byte, read under the size latched from the prefix
    always_comb begin
        exec_kind   = EX_NONE;
        exec_alu_op = ALU_NOP;
        exec_flags  = 1'b0;
        casez (b)
            8'b1000_1???: begin  // LD R,r
                exec_kind   = EX_LD_RR;
                exec_alu_op = ALU_MOVE;
            end
            8'b1???_0???: begin
                exec_kind  = EX_ARITH_RR;
                exec_flags = 1'b1;
                case (b[6:4])
                    3'd0: exec_alu_op = ALU_ADD;
                    3'd1: exec_alu_op = ALU_ADC;
                    3'd2: exec_alu_op = ALU_SUB;
                    3'd4: exec_alu_op = ALU_AND;
                    3'd5: exec_alu_op = ALU_XOR;
                    3'd6: exec_alu_op = ALU_OR;
                    3'd7: exec_alu_op = ALU_CP;
                    default: begin  // SBC is not supported
                        exec_kind  = EX_NONE;
                        exec_flags = 1'b0;
                    end
                endcase
            end
            8'b0110_????: begin  // INC/DEC #3
                exec_kind   = EX_INC_DEC;
                exec_alu_op = b[3] ? ALU_DEC : ALU_INC;
                exec_flags  = 1'b1;
            end
            8'h06: begin
                exec_kind   = EX_UNARY;
                exec_alu_op = ALU_CPL;
            end
            8'h07: begin
                exec_kind   = EX_UNARY;
                exec_alu_op = ALU_NEG;
                exec_flags  = 1'b1;
            end
            default: ;
        endcase
    end

    assign exec_reg = expand_reg(b[2:0], op_zz);

endmodule

/* hdl/phase_sequencer.sv */
// ----------------------------------------
// Phase machine: byte count, refill wait,
// latched operand size and command issue
// ----------------------------------------
`timescale 1ns/1ps

module phase_sequencer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cen,
    input  logic                         op_ok,
    input  cpu900_ctrl_pkg::lead_class_t lead_class,
    input  cpu900_isa_pkg::size_t        lead_zz,
    input  cpu900_isa_pkg::reg_code_t    lead_reg,
    input  cpu900_ctrl_pkg::exec_kind_t  exec_kind,
    input  cpu900_isa_pkg::alu_op_t      exec_alu_op,
    input  cpu900_isa_pkg::reg_code_t    exec_reg,
    input  logic                         exec_flags,
    output cpu900_ctrl_pkg::fetch_cnt_t  fetched,
    output cpu900_isa_pkg::size_t        op_zz,
    output logic                         issue,
    output cpu900_isa_pkg::alu_op_t      cmd_alu_op,
    output cpu900_isa_pkg::reg_code_t    cmd_dst,
    output cpu900_isa_pkg::reg_code_t    cmd_src,
    output cpu900_ctrl_pkg::we_mask_t    cmd_we,
    output logic                         cmd_flag_we,
    output logic                         cmd_smux,
    output logic                         cmd_inc_rfp,
    output logic                         cmd_dec_rfp,
    output cpu900_ctrl_pkg::imm_load_t   cmd_imm,
    output logic                         cmd_fill_wait
);
    import cpu900_isa_pkg::*;
    import cpu900_ctrl_pkg::*;

    phase_t    phase;
    phase_t    nx_phase;
    logic      refill;      // Fetch unit reloads its window
    logic      decode;
    reg_code_t prefix_reg;  // Also the LD R,# target during the fill
    we_mask_t  keep_we;     // Write mask held back until the fill

    assign decode = !rst && cen && op_ok && !refill;

    always_comb begin
        nx_phase      = phase;
        fetched       = 2'd0;
        issue         = 1'b0;
        cmd_alu_op    = ALU_NOP;
        cmd_dst       = prefix_reg;
        cmd_src       = prefix_reg;
        cmd_we        = '0;
        cmd_flag_we   = 1'b0;
        cmd_smux      = 1'b0;
        cmd_inc_rfp   = 1'b0;
        cmd_dec_rfp   = 1'b0;
        cmd_imm       = IMM_NONE;
        cmd_fill_wait = 1'b0;
        if (decode) begin
            case (phase)
                PH_FETCH: begin
                    fetched = 2'd1;
                    case (lead_class)
                        LEAD_CCF: begin
                            issue       = 1'b1;
                            cmd_alu_op  = ALU_CCF;
                            cmd_flag_we = 1'b1;
                        end
                        LEAD_INCF: begin
                            issue       = 1'b1;
                            cmd_inc_rfp = 1'b1;
                        end
                        LEAD_DECF: begin
                            issue       = 1'b1;
                            cmd_dec_rfp = 1'b1;
                        end
                        LEAD_LD_IMM: begin
                            fetched    = 2'd2;  // Opcode and low immediate byte
                            issue      = 1'b1;
                            cmd_alu_op = ALU_MOVE;
                            cmd_dst    = lead_reg;
                            cmd_src    = lead_reg;
                            cmd_smux   = 1'b1;
                            cmd_imm    = IMM_BYTE;
                            if (lead_zz == SIZE_BYTE) begin
                                cmd_we = size_mask(lead_zz);
                            end else begin
                                cmd_fill_wait = 1'b1;
                                nx_phase      = PH_FILL_IMM;
                            end
                        end
                        LEAD_REG_PREFIX: nx_phase = PH_EXEC;
                        default: ;  // NOP or undecodable byte
                    endcase
                end
                PH_EXEC: begin
                    fetched     = 2'd1;
                    nx_phase    = PH_FETCH;
                    issue       = exec_kind != EX_NONE;
                    cmd_alu_op  = exec_alu_op;
                    cmd_flag_we = exec_flags;
                    cmd_we      = size_mask(op_zz);
                    case (exec_kind)
                        EX_ARITH_RR, EX_LD_RR: begin
                            cmd_dst = exec_reg;
                            if (exec_alu_op == ALU_CP) begin
                                cmd_we = '0;  // Flags only
                            end
                        end
                        EX_INC_DEC: begin
                            cmd_smux = 1'b1;
                            cmd_imm  = IMM_SHORT3;
                        end
                        default: ;
                    endcase
                end
                PH_FILL_IMM: begin
                    issue      = 1'b1;
                    nx_phase   = PH_FETCH;
                    cmd_alu_op = ALU_MOVE;
                    cmd_smux   = 1'b1;
                    cmd_we     = keep_we;
                    if (op_zz == SIZE_WORD) begin
                        fetched = 2'd1;
                        cmd_imm = IMM_HI16;
                    end else begin
                        fetched = 2'd3;
                        cmd_imm = IMM_HI24;
                    end
                end
                default: nx_phase = PH_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= PH_FETCH;
            refill     <= 1'b0;
            op_zz      <= SIZE_BYTE;
            prefix_reg <= '0;
            keep_we    <= '0;
        end else if (cen) begin
            phase  <= nx_phase;
            refill <= fetched != 2'd0;  // One cen cycle after any consumption
            if (decode && phase == PH_FETCH &&
                (lead_class == LEAD_LD_IMM || lead_class == LEAD_REG_PREFIX)) begin
                op_zz      <= lead_zz;
                prefix_reg <= lead_reg;
                keep_we    <= size_mask(lead_zz);
            end
        end
    end

endmodule

/* verif/cpu900_decode_tb.sv */
// ----------------------------------------
// Testbench for the decode controller:
// clock, reset, byte-stream fetch model,
// reference model and command checker
// ----------------------------------------
`timescale 1ns/1ps

module cpu900_decode_tb;
    import cpu900_isa_pkg::*;
    import cpu900_ctrl_pkg::*;

    localparam int N_INSTR   = 300;
    localparam int CMD_LIMIT = 200;  // cen cycles allowed per command

    typedef struct packed {
        logic      active;     // Instruction produces a command
        logic      two_step;   // LD R,# word or long
        alu_op_t   alu_op;
        logic      smux;
        op_word_t  imm_first;  // Immediate after the first LD step
        op_word_t  imm;
        logic      chk_imm;
        logic      chk_regs;
        reg_code_t dst;
        reg_code_t src;
        we_mask_t  we;
        logic      flag_we;
        logic      inc_rfp;
        logic      dec_rfp;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        cen;
    op_word_t    op;
    logic        op_ok;
    fetch_cnt_t  fetched;
    alu_op_t     alu_op;
    op_word_t    alu_imm;
    logic        alu_smux;
    logic        alu_wait;
    logic        flag_we;
    logic        inc_rfp;
    logic        dec_rfp;
    we_mask_t    regs_we;
    reg_code_t   regs_dst;
    reg_code_t   regs_src;

    logic [7:0]  stream[$];   // Program bytes as the fetch unit sees them
    logic [39:0] instr_q[$];  // Same program, one entry per instruction
    int          ptr;         // Fetch pointer into stream

    cpu900_decode u_cpu900_decode (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (op),
        .op_ok    (op_ok),
        .fetched  (fetched),
        .alu_op   (alu_op),
        .alu_imm  (alu_imm),
        .alu_smux (alu_smux),
        .alu_wait (alu_wait),
        .flag_we  (flag_we),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp),
        .regs_we  (regs_we),
        .regs_dst (regs_dst),
        .regs_src (regs_src)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_on_error(string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_alu_op(string name, alu_op_t exp, alu_op_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, op_word_t exp, op_word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(string name, reg_code_t exp, reg_code_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_mask(string name, we_mask_t exp, we_mask_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(string name, fetch_cnt_t exp, fetch_cnt_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Register field to full register code
    function automatic reg_code_t reg_code_of(logic [2:0] r, logic [1:0] zz);
        int base;
        if (zz == 2'd0) begin
            return reg_code_t'(224 + 4 * (r >> 1) + (r[0] ? 0 : 1));
        end
        base = r[2] ? 240 : 224;
        return reg_code_t'(base + 4 * (r % 4));
    endfunction

    function automatic we_mask_t mask_of(logic [1:0] zz);
        return we_mask_t'(1 << zz);
    endfunction

    // Reference model, one instruction in, expected command out
    function automatic expect_t expected_for(logic [39:0] ins);
        expect_t    e;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [1:0] zz;
        reg_code_t  pr;
        e  = '0;
        b0 = ins[7:0];
        b1 = ins[15:8];
        if (b0 == 8'h12) begin
            e.active  = 1'b1;
            e.alu_op  = ALU_CCF;
            e.flag_we = 1'b1;
        end else if (b0 == 8'h0c) begin
            e.active  = 1'b1;
            e.inc_rfp = 1'b1;
        end else if (b0 == 8'h0d) begin
            e.active  = 1'b1;
            e.dec_rfp = 1'b1;
        end else if (!b0[3] && b0[7:4] >= 4'd2 && b0[7:4] <= 4'd4) begin
            zz          = 2'(b0[7:4] - 4'd2);
            e.active    = 1'b1;
            e.two_step  = zz != 2'd0;
            e.alu_op    = ALU_MOVE;
            e.smux      = 1'b1;
            e.chk_imm   = 1'b1;
            e.chk_regs  = 1'b1;
            e.imm_first = {24'd0, b1};
            case (zz)
                2'd0:    e.imm = {24'd0, b1};
                2'd1:    e.imm = {16'd0, ins[23:8]};
                default: e.imm = ins[39:8];
            endcase
            e.dst = reg_code_of(b0[2:0], zz);
            e.src = e.dst;
            e.we  = mask_of(zz);
        end else if (b0[7:6] == 2'b11 && b0[3] && b0[5:4] != 2'd3) begin
            zz         = b0[5:4];
            pr         = reg_code_of(b0[2:0], zz);
            e.dst      = pr;
            e.src      = pr;
            e.we       = mask_of(zz);
            e.chk_regs = 1'b1;
            if (b1[7:3] == 5'b10001) begin
                e.active = 1'b1;
                e.alu_op = ALU_MOVE;
                e.dst    = reg_code_of(b1[2:0], zz);
            end else if (b1[7] && !b1[3] && b1[6:4] != 3'd3) begin
                e.active  = 1'b1;
                e.flag_we = 1'b1;
                e.dst     = reg_code_of(b1[2:0], zz);
                case (b1[6:4])
                    3'd0:    e.alu_op = ALU_ADD;
                    3'd1:    e.alu_op = ALU_ADC;
                    3'd2:    e.alu_op = ALU_SUB;
                    3'd4:    e.alu_op = ALU_AND;
                    3'd5:    e.alu_op = ALU_XOR;
                    3'd6:    e.alu_op = ALU_OR;
                    default: begin
                        e.alu_op = ALU_CP;
                        e.we     = '0;  // Compare touches flags only
                    end
                endcase
            end else if (b1[7:4] == 4'b0110) begin
                e.active  = 1'b1;
                e.alu_op  = b1[3] ? ALU_DEC : ALU_INC;
                e.smux    = 1'b1;
                e.chk_imm = 1'b1;
                e.imm     = {29'd0, b1[2:0]};
                e.flag_we = 1'b1;
            end else if (b1 == 8'h06 || b1 == 8'h07) begin
                e.active  = 1'b1;
                e.alu_op  = b1[0] ? ALU_NEG : ALU_CPL;
                e.flag_we = b1[0];
            end
        end
        return e;
    endfunction

    task automatic add_instr(logic [39:0] ins, int len);
        int k;
        instr_q.push_back(ins);
        for (k = 0; k < len; k++) begin
            stream.push_back(ins[8*k +: 8]);
        end
    endtask

    // First ten instructions walk every kind once
    task automatic build_stream;
        int          i;
        int          kind;
        logic [2:0]  r;
        logic [2:0]  r2;
        logic [2:0]  ooo;
        logic [1:0]  zz;
        logic [7:0]  lead;
        logic [7:0]  pre;
        logic [31:0] imm;
        for (i = 0; i < N_INSTR; i++) begin
            kind = (i < 10) ? i : int'($urandom % 10);
            r    = 3'($urandom);
            r2   = 3'($urandom);
            zz   = 2'($urandom % 3);
            imm  = $urandom;
            ooo  = 3'($urandom % 7);
            if (ooo >= 3'd3) begin
                ooo = ooo + 3'd1;  // Skip SBC
            end
            lead = {4'(zz + 2), 1'b0, r};
            pre  = {2'b11, zz, 1'b1, r};
            case (kind)
                0: add_instr(40'h00, 1);
                1: add_instr(40'h12, 1);
                2: add_instr(40'h0c, 1);
                3: add_instr(40'h0d, 1);
                4: begin
                    if (zz == 2'd0) begin
                        add_instr({24'd0, imm[7:0], lead}, 2);
                    end else if (zz == 2'd1) begin
                        add_instr({16'd0, imm[15:0], lead}, 3);
                    end else begin
                        add_instr({imm, lead}, 5);
                    end
                end
                5: add_instr({24'd0, 1'b1, ooo, 1'b0, r2, pre}, 2);
                6: add_instr({24'd0, 5'b10001, r2, pre}, 2);
                7: add_instr({24'd0, 4'b0110, 1'($urandom), r2, pre}, 2);
                8: add_instr({24'd0, ($urandom % 2) ? 8'h07 : 8'h06, pre}, 2);
                default: begin
                    case ($urandom % 4)
                        0: add_instr(40'h01, 1);
                        1: add_instr(40'hf8, 1);  // zz of 3
                        2: add_instr(40'h80, 1);
                        default: add_instr({24'd0, 8'hb0, pre}, 2);  // SBC slot
                    endcase
                end
            endcase
        end
    endtask

    function automatic op_word_t window_at(int p);
        op_word_t w;
        int       k;
        w = '0;
        for (k = 0; k < 4; k++) begin
            if (p + k < stream.size()) begin
                w[8*k +: 8] = stream[p + k];
            end
        end
        return w;
    endfunction

    function automatic logic pulse_seen();
        return regs_we != '0 || flag_we || inc_rfp || dec_rfp;
    endfunction

    // Fetch unit model
    task automatic drive_stream;
        fetch_cnt_t step;
        logic       last_nz;
        last_nz = 1'b0;
        forever begin
            @(negedge clk);
            step = fetched;
            if (cen) begin
                if (last_nz && step != 2'd0) begin
                    stop_on_error("fetched was nonzero in two consecutive cen cycles");
                end
                last_nz = step != 2'd0;
            end
            @(posedge clk);
            #2;
            ptr   = ptr + step;
            cen   = ($urandom % 10) < 8;
            op_ok = ptr < stream.size() && ($urandom % 10) < 9;
            op    = window_at(ptr);
        end
    endtask

    task automatic next_cen_cycle;
        int n;
        n = 0;
        @(posedge clk);
        while (!cen && n < 50) begin
            n++;
            @(posedge clk);
        end
        if (!cen) begin
            stop_on_error("cen stayed low for 50 clock cycles");
        end
        #1;  // Registered outputs settle
    endtask

    task automatic check_reset_state;
        check_count("fetched", 2'd0, fetched);
        check_alu_op("alu_op", ALU_NOP, alu_op);
        check_word("alu_imm", '0, alu_imm);
        check_bit("alu_smux", 1'b0, alu_smux);
        check_bit("alu_wait", 1'b0, alu_wait);
        check_mask("regs_we", '0, regs_we);
        check_bit("flag_we", 1'b0, flag_we);
        check_bit("inc_rfp", 1'b0, inc_rfp);
        check_bit("dec_rfp", 1'b0, dec_rfp);
        check_reg("regs_dst", '0, regs_dst);
        check_reg("regs_src", '0, regs_src);
    endtask

    task automatic compare_command(expect_t e);
        check_mask("regs_we", e.we, regs_we);
        check_bit("flag_we", e.flag_we, flag_we);
        check_bit("inc_rfp", e.inc_rfp, inc_rfp);
        check_bit("dec_rfp", e.dec_rfp, dec_rfp);
        check_bit("alu_wait", 1'b0, alu_wait);
        check_alu_op("alu_op", e.alu_op, alu_op);
        if (e.chk_regs) begin
            check_reg("regs_dst", e.dst, regs_dst);
            check_reg("regs_src", e.src, regs_src);
            check_bit("alu_smux", e.smux, alu_smux);
        end
        if (e.chk_imm) begin
            check_word("alu_imm", e.imm, alu_imm);
        end
    endtask

    // first_step waits for alu_wait to rise on LD R,# word or long
    task automatic await_command(expect_t e, logic first_step);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            if (n == CMD_LIMIT) begin
                stop_on_error("Timeout, the controller stopped issuing commands");
            end
            next_cen_cycle();
            n++;
            if (first_step) begin
                if (pulse_seen()) begin
                    stop_on_error("Write pulse seen before the immediate fill of LD R,#");
                end
                if (alu_wait) begin
                    check_alu_op("alu_op", ALU_MOVE, alu_op);
                    check_word("alu_imm", e.imm_first, alu_imm);
                    check_reg("regs_dst", e.dst, regs_dst);
                    check_reg("regs_src", e.src, regs_src);
                    check_bit("alu_smux", 1'b1, alu_smux);
                    done = 1'b1;
                end
            end else if (pulse_seen()) begin
                compare_command(e);
                done = 1'b1;
            end else begin
                check_bit("alu_wait", e.two_step, alu_wait);  // High only during fill
            end
        end
    endtask

    task automatic check_stream;
        expect_t e;
        int      i;
        int      n;
        for (i = 0; i < instr_q.size(); i++) begin
            e = expected_for(instr_q[i]);
            if (e.active) begin
                if (e.two_step) begin
                    await_command(e, 1'b1);
                end
                await_command(e, 1'b0);
            end
        end
        n = 0;
        while (ptr != stream.size()) begin
            if (n == CMD_LIMIT) begin
                stop_on_error("Fetch pointer never reached the end of the byte stream");
            end
            next_cen_cycle();
            n++;
        end
        repeat (10) begin
            next_cen_cycle();
            if (pulse_seen() || alu_wait) begin
                stop_on_error("Controller issued a command after the stream ended");
            end
        end
    endtask

    initial begin
        rst   = 1'b1;
        cen   = 1'b1;
        op_ok = 1'b1;
        op    = '0;
        ptr   = 0;
        void'($urandom(35668));
        build_stream();
        op = window_at(0);  // Live bytes while rst is high
        repeat (8) begin
            @(negedge clk);
            check_reset_state();
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        fork
            drive_stream();
        join_none
        check_stream();
        $display("All tests passed!");
        $finish;
    end

endmodule
